// ==== flist.f ====
hw/uart_pkg.sv
hw/uart_cfg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
verif/uart_props.sv
verif/uart_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the UART testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module uart_tb -f flist.f \
    && ./obj_dir/Vuart_tb > sim.log 2>&1 \
    || echo "build or run stopped early" >> sim.log
cat sim.log
! grep -q "sim failed" sim.log && grep -q "sim passed" sim.log \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }

// ==== verif/uart_tb.sv ====
// UART core testbench

`timescale 1ns/100ps
`default_nettype none

module uart_tb import uart_pkg::*; ();

    localparam int  CLK_NS     = 40;
    localparam int  N_FRAMES   = 92;  // frames sent or injected
    localparam int  MAX_DIV    = 8;
    localparam real TIMEOUT_NS = 1.2 * N_FRAMES * 11 * MAX_DIV * CLK_NS + 16 * CLK_NS;

    logic                 clk;
    logic                 nRst;
    logic                 cfg_wr;
    logic                 cfg_addr;
    logic [CFG_W-1:0]     cfg_wdata;
    logic                 tx_start;
    logic [DATA_BITS-1:0] tx_byte;
    logic                 tx_ready;
    logic                 tx_serial;
    logic                 rx_serial;
    logic                 rx_valid;
    logic [DATA_BITS-1:0] rx_byte;
    logic                 parity_err;
    logic                 frame_err;
    logic                 loop_sel;
    logic                 tb_line;
    integer               seed;
    int                   errors;
    logic [DATA_BITS-1:0] exp_byte_q[$];
    logic                 exp_perr_q[$];
    logic                 exp_ferr_q[$];
    string                exp_name_q[$];

    assign rx_serial = loop_sel ? tx_serial : tb_line;  // loopback or injected frames

    uart_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic check_byte(input string name, input logic [DATA_BITS-1:0] exp,
                              input logic [DATA_BITS-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s expected %02h actual %02h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s expected %b actual %b", name, exp, act);
        end
    endtask

    // bit 0 start, bits 8..1 data LSB first, then parity and stop
    function automatic logic [10:0] frame_bits(input logic [DATA_BITS-1:0] b,
                                               input logic pen, input logic podd,
                                               output logic pbit);
        int          ones;
        logic [10:0] f;
        ones = 0;
        for (int i = 0; i < DATA_BITS; i++) begin
            if (b[i]) ones++;
        end
        pbit = (ones % 2 == 1) ^ podd;  // even makes total ones even
        f = {2'b11, b, 1'b0};
        if (pen) f[9] = pbit;
        return f;
    endfunction

    task automatic expect_rx(input string name, input logic [DATA_BITS-1:0] b,
                             input logic perr, input logic ferr);
        exp_name_q.push_back(name);
        exp_byte_q.push_back(b);
        exp_perr_q.push_back(perr);
        exp_ferr_q.push_back(ferr);
    endtask

    task automatic cfg_write(input logic addr, input logic [CFG_W-1:0] data);
        @(posedge clk);
        #2;
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #2;
        cfg_wr = 1'b0;
    endtask

    // follows tx_serial at mid-bit until tx_ready returns
    task automatic send_byte(input string name, input logic [DATA_BITS-1:0] b,
                             input int d, input logic pen, input logic podd);
        logic [10:0] f;
        logic        pbit;
        int          len;
        int          total;
        f = frame_bits(b, pen, podd, pbit);
        len = 10 + int'(pen);
        total = len * d + 1;
        if (loop_sel) expect_rx(name, b, 1'b0, 1'b0);
        @(posedge clk);
        #2;
        tx_start = 1'b1;
        tx_byte  = b;
        @(posedge clk);  // accepting edge
        #2;
        tx_start = 1'b0;
        for (int n = 0; n <= total; n++) begin
            @(negedge clk);
            if (n % d == d / 2 && n / d < len) check_flag({name, " bit"}, f[n / d], tx_serial);
            check_flag({name, " tx_ready"}, n == total, tx_ready);
        end
    endtask

    task automatic drive_frame(input string name, input logic [DATA_BITS-1:0] b, input int d,
                               input logic pen, input logic flip_par, input logic stop_val);
        logic [10:0] f;
        logic        pbit;
        int          len;
        f = frame_bits(b, pen, 1'b0, pbit);
        len = 10 + int'(pen);
        if (pen) f[9] = pbit ^ flip_par;
        f[len - 1] = stop_val;
        expect_rx(name, b, pen & flip_par, ~stop_val);
        for (int i = 0; i < len + 2; i++) begin  // two idle bits after the frame
            @(posedge clk);
            #2;
            tb_line = (i < len) ? f[i] : 1'b1;
            repeat (d - 1) @(posedge clk);
        end
    endtask

    always @(negedge clk) begin
        if (nRst && rx_valid) begin
            if (exp_byte_q.size() == 0) begin
                errors++;
                $display("rx_valid pulsed with no frame in flight");
            end else begin
                check_byte({exp_name_q[0], " rx_byte"}, exp_byte_q.pop_front(), rx_byte);
                check_flag({exp_name_q[0], " parity_err"}, exp_perr_q.pop_front(), parity_err);
                check_flag({exp_name_q.pop_front(), " frame_err"}, exp_ferr_q.pop_front(),
                           frame_err);
            end
        end
    end

    initial begin
        logic [DATA_BITS-1:0] b;
        logic [CFG_W-1:0]     par_word;
        seed      = 32'h95d6;
        errors    = 0;
        nRst      = 1'b0;
        cfg_wr    = 1'b0;
        cfg_addr  = 1'b0;
        cfg_wdata = '0;
        tx_start  = 1'b0;
        tx_byte   = '0;
        tb_line   = 1'b1;
        loop_sel  = 1'b1;
        repeat (8) @(posedge clk);
        check_flag("reset tx_serial", 1'b1, tx_serial);
        check_flag("reset tx_ready", 1'b1, tx_ready);
        check_flag("reset rx_valid", 1'b0, rx_valid);
        repeat (8) @(posedge clk);
        #2;
        nRst = 1'b1;
        @(negedge clk);
        check_flag("post reset tx_serial", 1'b1, tx_serial);
        check_flag("post reset tx_ready", 1'b1, tx_ready);
        check_flag("post reset rx_valid", 1'b0, rx_valid);

        cfg_write(ADDR_DIV, 16'd8);
        cfg_write(ADDR_PAR, 16'h0001);
        for (int i = 0; i < 20; i++) send_byte("tx_wave", 8'($random(seed)), 8, 1'b1, 1'b0);

        for (int m = 0; m < 3; m++) begin  // none, even, odd
            par_word = (m == 0) ? 16'h0000 : ((m == 1) ? 16'h0001 : 16'h0003);
            cfg_write(ADDR_PAR, par_word);
            for (int i = 0; i < 20; i++) begin
                send_byte("loopback", 8'($random(seed)), 8, m != 0, m == 2);
            end
        end

        cfg_write(ADDR_DIV, 16'd2);  // clamps to MIN_DIV
        send_byte("cfg_min_div", 8'($random(seed)), 4, 1'b1, 1'b1);
        cfg_write(ADDR_PAR, 16'h0001);
        fork
            send_byte("cfg_inflight", 8'($random(seed)), 4, 1'b1, 1'b0);
            begin
                repeat (10) @(posedge clk);
                cfg_write(ADDR_PAR, 16'h0003);
            end
        join
        send_byte("cfg_next", 8'($random(seed)), 4, 1'b1, 1'b1);

        loop_sel = 1'b0;
        cfg_write(ADDR_PAR, 16'h0001);
        for (int i = 0; i < 4; i++) drive_frame("rx_par_err", 8'($random(seed)), 4, 1, 1, 1);
        cfg_write(ADDR_PAR, 16'h0000);
        for (int i = 0; i < 4; i++) drive_frame("rx_frame_err", 8'($random(seed)), 4, 0, 0, 0);

        loop_sel = 1'b1;
        b = 8'($random(seed));
        fork
            send_byte("busy_start", b, 4, 1'b0, 1'b0);
            begin
                repeat (12) @(posedge clk);
                #2;
                tx_start = 1'b1;
                tx_byte  = ~b;  // must not be sent
                @(posedge clk);
                #2;
                tx_start = 1'b0;
            end
        join

        while (exp_byte_q.size() != 0) @(posedge clk);
        repeat (60) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("simulation timed out before all frames were checked");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/uart_props.sv ====
// UART core assertions

`timescale 1ns/100ps
`default_nettype none

module uart_props import uart_pkg::*; (
    input logic            clk,
    input logic            nRst,
    input logic            tx_start,
    input logic            tx_ready,
    input logic            tx_serial,
    input logic            rx_valid,
    input logic [ST_W-1:0] tx_state
);

    a_idle_high: assert property (@(posedge clk) disable iff (!nRst) tx_ready |-> tx_serial)
        else $error("line low while transmitter idle");

    a_valid_pulse: assert property (@(posedge clk) disable iff (!nRst) rx_valid |=> !rx_valid)
        else $error("rx_valid high for two cycles");

    a_busy: assert property (@(posedge clk) disable iff (!nRst)
        (tx_ready && tx_start) |=> !tx_ready)
        else $error("tx_ready not dropped after accepted start");

    // ready may only rise out of the clean cycle
    a_hold: assert property (@(posedge clk) disable iff (!nRst)
        (!tx_ready && tx_state != TX_CLEAN) |=> !tx_ready)
        else $error("tx_ready rose before frame end");

endmodule

bind uart_top uart_props u_props (.*, .tx_state(u_tx.state));

`default_nettype wire

// ==== hw/uart_top.sv ====
// UART core top level

`timescale 1ns/100ps
`default_nettype none

module uart_top import uart_pkg::*; (
    input  logic                 clk,
    input  logic                 nRst,
    input  logic                 cfg_wr,
    input  logic                 cfg_addr,
    input  logic [CFG_W-1:0]     cfg_wdata,
    input  logic                 tx_start,
    input  logic [DATA_BITS-1:0] tx_byte,
    output logic                 tx_ready,
    output logic                 tx_serial,
    input  logic                 rx_serial,
    output logic                 rx_valid,
    output logic [DATA_BITS-1:0] rx_byte,
    output logic                 parity_err,
    output logic                 frame_err
);

    logic [DIV_W-1:0] clks_per_bit;
    logic             parity_en;
    logic             parity_odd;

    uart_cfg u_cfg (
        .clk          (clk),
        .nRst         (nRst),
        .cfg_wr       (cfg_wr),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .clks_per_bit (clks_per_bit),
        .parity_en    (parity_en),
        .parity_odd   (parity_odd)
    );

    uart_tx u_tx (
        .clk          (clk),
        .nRst         (nRst),
        .tx_start     (tx_start),
        .tx_byte      (tx_byte),
        .clks_per_bit (clks_per_bit),
        .parity_en    (parity_en),
        .parity_odd   (parity_odd),
        .tx_ready     (tx_ready),
        .tx_serial    (tx_serial)
    );

    uart_rx u_rx (
        .clk          (clk),
        .nRst         (nRst),
        .rx_serial    (rx_serial),
        .clks_per_bit (clks_per_bit),
        .parity_en    (parity_en),
        .parity_odd   (parity_odd),
        .rx_valid     (rx_valid),
        .rx_byte      (rx_byte),
        .parity_err   (parity_err),
        .frame_err    (frame_err)
    );

endmodule

`default_nettype wire

// ==== hw/uart_rx.sv ====
// UART frame receiver

`timescale 1ns/100ps
`default_nettype none

module uart_rx import uart_pkg::*; (
    input  logic                 clk,
    input  logic                 nRst,
    input  logic                 rx_serial,
    input  logic [DIV_W-1:0]     clks_per_bit,
    input  logic                 parity_en,
    input  logic                 parity_odd,
    output logic                 rx_valid,
    output logic [DATA_BITS-1:0] rx_byte,
    output logic                 parity_err,
    output logic                 frame_err
);

    logic                 rx_meta;
    logic                 rx_sync;
    logic                 rx_prev;
    logic                 fall;
    logic [ST_W-1:0]      state;
    logic [DIV_W-1:0]     clk_cnt;
    logic [DIV_W-1:0]     limit;
    logic                 bit_end;
    logic [2:0]           bit_idx;
    logic [DIV_W-1:0]     div_q;
    logic                 par_en_q;
    logic                 par_odd_q;
    logic                 par_bit_q;
    logic [DATA_BITS-1:0] shreg;
    logic                 stop_hit;

    // two-flop synchronizer plus edge history
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_serial;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall     = rx_prev & ~rx_sync;
    assign limit    = (state == RX_START) ? (div_q >> 1) - 1'b1 : div_q - 1'b1;
    assign bit_end  = (clk_cnt == limit);
    assign stop_hit = (state == RX_STOP) & bit_end;

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            clk_cnt <= '0;
        end else if (state == RX_IDLE || bit_end) begin
            clk_cnt <= '0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            state     <= RX_IDLE;
            bit_idx   <= '0;
            div_q     <= RESET_DIV;
            par_en_q  <= 1'b0;
            par_odd_q <= 1'b0;
        end else begin
            case (state)
                RX_IDLE: begin
                    bit_idx <= '0;
                    if (fall) begin
                        state     <= RX_START;
                        div_q     <= clks_per_bit;
                        par_en_q  <= parity_en;
                        par_odd_q <= parity_odd;
                    end
                end
                RX_START: begin
                    if (bit_end) state <= rx_sync ? RX_IDLE : RX_DATA;  // glitch check
                end
                RX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'(DATA_BITS - 1)) begin
                            state <= par_en_q ? RX_PARITY : RX_STOP;
                        end
                    end
                end
                RX_PARITY: begin
                    if (bit_end) state <= RX_STOP;
                end
                RX_STOP: begin
                    if (bit_end) state <= RX_IDLE;
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // mid-bit samples
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) shreg <= {rx_sync, shreg[DATA_BITS-1:1]};
        if (state == RX_PARITY && bit_end) par_bit_q <= rx_sync;
        if (stop_hit) rx_byte <= shreg;
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            rx_valid   <= 1'b0;
            parity_err <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            rx_valid <= stop_hit;
            if (stop_hit) begin
                parity_err <= par_en_q & (^shreg ^ par_bit_q ^ par_odd_q);
                frame_err  <= ~rx_sync;  // stop bit must be high
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
// UART frame transmitter

`timescale 1ns/100ps
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  logic                 clk,
    input  logic                 nRst,
    input  logic                 tx_start,
    input  logic [DATA_BITS-1:0] tx_byte,
    input  logic [DIV_W-1:0]     clks_per_bit,
    input  logic                 parity_en,
    input  logic                 parity_odd,
    output logic                 tx_ready,
    output logic                 tx_serial
);

    logic [ST_W-1:0]      state;
    logic [DIV_W-1:0]     clk_cnt;
    logic [2:0]           bit_idx;
    logic [DIV_W-1:0]     div_q;
    logic                 par_en_q;
    logic                 par_odd_q;
    logic [DATA_BITS-1:0] data_q;
    logic                 accept;
    logic                 bit_end;
    logic                 par_bit;

    assign tx_ready = (state == TX_IDLE);
    assign accept   = tx_ready & tx_start;
    assign bit_end  = (clk_cnt == div_q - 1'b1);
    assign par_bit  = ^data_q ^ par_odd_q;  // even unless odd selected

    // bit-time counter
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            clk_cnt <= '0;
        end else if (state == TX_IDLE || state == TX_CLEAN || bit_end) begin
            clk_cnt <= '0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            state     <= TX_IDLE;
            bit_idx   <= '0;
            div_q     <= RESET_DIV;
            par_en_q  <= 1'b0;
            par_odd_q <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    bit_idx <= '0;
                    if (tx_start) begin
                        state     <= TX_START;
                        div_q     <= clks_per_bit;  // config frozen for this frame
                        par_en_q  <= parity_en;
                        par_odd_q <= parity_odd;
                    end
                end
                TX_START: begin
                    if (bit_end) state <= TX_DATA;
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'(DATA_BITS - 1)) begin
                            state <= par_en_q ? TX_PARITY : TX_STOP;
                        end
                    end
                end
                TX_PARITY: begin
                    if (bit_end) state <= TX_STOP;
                end
                TX_STOP: begin
                    if (bit_end) state <= TX_CLEAN;  // full stop bit
                end
                TX_CLEAN: begin
                    state <= TX_IDLE;
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) data_q <= tx_byte;
    end

    always_comb begin
        case (state)
            TX_START:  tx_serial = 1'b0;
            TX_DATA:   tx_serial = data_q[bit_idx];  // LSB first
            TX_PARITY: tx_serial = par_bit;
            default:   tx_serial = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/uart_cfg.sv ====
// UART configuration registers

`timescale 1ns/100ps
`default_nettype none

module uart_cfg import uart_pkg::*; (
    input  logic             clk,
    input  logic             nRst,
    input  logic             cfg_wr,
    input  logic             cfg_addr,
    input  logic [CFG_W-1:0] cfg_wdata,
    output logic [DIV_W-1:0] clks_per_bit,
    output logic             parity_en,
    output logic             parity_odd
);

    logic [DIV_W-1:0] div_in;
    logic [DIV_W-1:0] div_clamped;

    assign div_in      = cfg_wdata[DIV_W-1:0];
    assign div_clamped = (div_in < MIN_DIV) ? MIN_DIV : div_in;  // floor at MIN_DIV

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            clks_per_bit <= RESET_DIV;
            parity_en    <= 1'b0;
            parity_odd   <= 1'b0;
        end else if (cfg_wr) begin
            case (cfg_addr)
                ADDR_DIV: begin
                    clks_per_bit <= div_clamped;
                end
                ADDR_PAR: begin
                    parity_en  <= cfg_wdata[0];
                    parity_odd <= cfg_wdata[1];
                end
                default: begin
                    clks_per_bit <= clks_per_bit;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/uart_pkg.sv ====
// UART shared constants

`default_nettype none

package uart_pkg;

    // frame and register widths
    localparam int DATA_BITS = 8;
    localparam int DIV_W     = 11;
    localparam int CFG_W     = 16;
    localparam int ST_W      = 3;

    localparam logic [DIV_W-1:0] RESET_DIV = 11'd1250;  // clocks per bit after reset
    localparam logic [DIV_W-1:0] MIN_DIV   = 11'd4;     // keeps half-bit wait nonzero

    // config register map
    localparam logic ADDR_DIV = 1'b0;
    localparam logic ADDR_PAR = 1'b1;  // bit0 enable, bit1 odd

    // transmitter states
    localparam logic [ST_W-1:0] TX_IDLE   = 3'b001;
    localparam logic [ST_W-1:0] TX_START  = 3'b010;
    localparam logic [ST_W-1:0] TX_DATA   = 3'b011;
    localparam logic [ST_W-1:0] TX_STOP   = 3'b100;
    localparam logic [ST_W-1:0] TX_CLEAN  = 3'b101;
    localparam logic [ST_W-1:0] TX_PARITY = 3'b110;

    // receiver states
    localparam logic [ST_W-1:0] RX_IDLE   = 3'b000;
    localparam logic [ST_W-1:0] RX_START  = 3'b001;
    localparam logic [ST_W-1:0] RX_DATA   = 3'b010;
    localparam logic [ST_W-1:0] RX_PARITY = 3'b011;
    localparam logic [ST_W-1:0] RX_STOP   = 3'b100;

endpackage

`default_nettype wire
